//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = eccMemTb
FILELIST = src.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/eccAxiFront.sv
`timescale 1ns/10ps

module eccAxiFront import eccPkg::*; #(
   parameter int DEPTH = 64
) (
   input logic clk,
   input logic rstN,
   input logic awValid,
   output logic awReady,
   input axiAddrT awAddr,
   input logic wValid,
   output logic wReady,
   input dataWordT wData,
   output logic bValid,
   input logic bReady,
   output respT bResp,
   input logic arValid,
   output logic arReady,
   input axiAddrT arAddr,
   output logic rValid,
   input logic rReady,
   output dataWordT rData,
   output respT rResp,
   eccPipeIf.source req,
   output codeWordT injMask,
   input logic injUsed,
   input logic rspValid,
   input dataWordT rspData,
   input logic rspCorrected,
   input logic rspUncorrectable
);

   localparam int IDX_W = $clog2(DEPTH);

   typedef enum logic [1:0] {stIdle, stWaitPipe, stRespond} stateT;

   stateT state;
   logic wrAccept, rdAccept, accept;
   axiAddrT curAddr;
   logic dataHit;
   // captured at the handshake
   logic isWrQ, hitQ;
   axiAddrT addrQ;
   dataWordT wDataQ;
   // completion of the three kinds of access
   logic regDone, wrDone, rdDone;
   respT regResp;
   dataWordT regRdata;
   cntT corrCnt, uncorrCnt;

   // pending write wins over read
   assign wrAccept = (state == stIdle) && awValid && wValid;
   assign rdAccept = (state == stIdle) && !awValid && arValid;
   assign accept = wrAccept || rdAccept;
   assign awReady = wrAccept;
   assign wReady = wrAccept;
   assign arReady = rdAccept;

   assign curAddr = wrAccept ? awAddr : arAddr;
   // only in-range data words go to the pipeline
   assign dataHit = (curAddr < REG_BASE) && (curAddr[11:2] < 10'(DEPTH));

   // register accesses and bad addresses finish one cycle after handshake
   assign regDone = (state == stWaitPipe) && !hitQ;
   assign wrDone = (state == stWaitPipe) && hitQ && isWrQ && injUsed;
   assign rdDone = (state == stWaitPipe) && hitQ && !isWrQ && rspValid;

   always_comb begin
      regResp = RESP_OKAY;
      regRdata = '0;
      case (addrQ)
         REG_INJ_LO: regRdata = injMask[31:0];
         REG_INJ_HI: regRdata = injMask[63:32];
         REG_CORR_CNT: regRdata = dataWordT'(corrCnt);
         REG_UNCORR_CNT: regRdata = dataWordT'(uncorrCnt);
         default: regResp = RESP_SLVERR;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= stIdle;
         req.valid <= 1'b0;
         bValid <= 1'b0;
         rValid <= 1'b0;
         injMask <= '0;
         corrCnt <= '0;
         uncorrCnt <= '0;
      end else begin
         req.valid <= 1'b0;
         // one-shot mask gone after the write that used it
         if (injUsed) begin
            injMask <= '0;
         end
         case (state)
            stIdle: begin
               if (accept) begin
                  state <= stWaitPipe;
                  req.valid <= dataHit;
               end
            end
            stWaitPipe: begin
               if (regDone || wrDone || rdDone) begin
                  state <= stRespond;
                  bValid <= isWrQ;
                  rValid <= !isWrQ;
               end
               if (regDone && isWrQ) begin
                  // any write to a counter clears it
                  case (addrQ)
                     REG_INJ_LO: injMask[31:0] <= wDataQ;
                     REG_INJ_HI: injMask[63:32] <= wDataQ;
                     REG_CORR_CNT: corrCnt <= '0;
                     REG_UNCORR_CNT: uncorrCnt <= '0;
                     default: ;
                  endcase
               end
               if (rdDone) begin
                  // saturate at all ones
                  if (rspCorrected && corrCnt != '1) begin
                     corrCnt <= corrCnt + cntT'(1);
                  end
                  if (rspUncorrectable && uncorrCnt != '1) begin
                     uncorrCnt <= uncorrCnt + cntT'(1);
                  end
               end
            end
            stRespond: begin
               // hold response until the master takes it
               if ((bValid && bReady) || (rValid && rReady)) begin
                  bValid <= 1'b0;
                  rValid <= 1'b0;
                  state <= stIdle;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   // request payload and access info
   always_ff @(posedge clk) begin
      if (accept) begin
         isWrQ <= wrAccept;
         hitQ <= dataHit;
         addrQ <= curAddr;
         wDataQ <= wData;
         req.wr <= wrAccept;
         req.idx <= curAddr[IDX_W+1:2];
         req.data <= wData;
      end
   end

   // front never sends a codeword
   assign req.code = '0;

   // response payload stays stable while valid is held
   always_ff @(posedge clk) begin
      if (regDone) begin
         bResp <= regResp;
         rResp <= regResp;
         rData <= regRdata;
      end
      if (wrDone) begin
         bResp <= RESP_OKAY;
      end
      if (rdDone) begin
         rData <= rspData;
         // uncorrectable word -> SLVERR
         rResp <= rspUncorrectable ? RESP_SLVERR : RESP_OKAY;
      end
   end

   // one item in flight means results only come back while waiting
   assert property (@(posedge clk) disable iff (!rstN) rspValid |-> state == stWaitPipe)
      else $error("pipeline response outside of wait state");

endmodule

//--- hw/eccDecodeStage.sv
`timescale 1ns/10ps

module eccDecodeStage import eccPkg::*; (
   input logic clk,
   input logic rstN,
   eccPipeIf.sink rd,
   output logic rspValid,
   output dataWordT rspData,
   output logic rspCorrected,
   output logic rspUncorrectable
);

   dataWordT fixedData;
   logic [7:0] nibAny;
   logic [7:0] nibMulti;

   // one decoder per stored byte
   for (genvar n = 0; n < 8; n++) begin : gNib
      hammingNibbleDecoder uDec (
         .codeIn(rd.code[8*n +: 8]),
         .dataOut(fixedData[4*n +: 4]),
         .errAny(nibAny[n]),
         .errMulti(nibMulti[n])
      );
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         rspValid <= 1'b0;
      end else begin
         rspValid <= rd.valid;
      end
   end

   // any double error makes the whole word bad
   always_ff @(posedge clk) begin
      rspData <= fixedData;
      rspUncorrectable <= |nibMulti;
      rspCorrected <= (|nibAny) && !(|nibMulti);
   end

endmodule

//--- hw/eccEncodeStage.sv
`timescale 1ns/10ps

module eccEncodeStage import eccPkg::*; (
   input logic clk,
   input logic rstN,
   input codeWordT injMask,
   output logic injUsed,
   eccPipeIf.sink req,
   eccPipeIf.source store
);

   codeWordT encoded;

   // p0 = d0^d1^d2, p1 = d0^d1^d3, p2 = d0^d2^d3, p4 = d1^d2^d3
   function automatic codeByteT encodeNibble(nibbleT d);
      codeByteT c;
      c[0] = d[0] ^ d[1] ^ d[2];
      c[1] = d[0] ^ d[1] ^ d[3];
      c[2] = d[0] ^ d[2] ^ d[3];
      c[3] = d[0];
      c[4] = d[1] ^ d[2] ^ d[3];
      c[5] = d[1];
      c[6] = d[2];
      c[7] = d[3];
      return c;
   endfunction

   // nibble n -> byte n
   always_comb begin
      for (int n = 0; n < 8; n++) begin
         encoded[8*n +: 8] = encodeNibble(req.data[4*n +: 4]);
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         store.valid <= 1'b0;
         injUsed <= 1'b0;
      end else begin
         store.valid <= req.valid;
         // front clears its mask on this pulse, also uses it as write ack
         injUsed <= req.valid && req.wr;
      end
   end

   always_ff @(posedge clk) begin
      store.wr <= req.wr;
      store.idx <= req.idx;
      // mask flips chosen codeword bits, reads only carry the index
      store.code <= req.wr ? (encoded ^ injMask) : '0;
   end

   // raw data stops here
   assign store.data = '0;

endmodule

//--- hw/eccMemTop.sv
`timescale 1ns/10ps

module eccMemTop import eccPkg::*; #(
   parameter int DEPTH = 64
) (
   input logic clk,
   input logic rstN,
   input logic awValid,
   output logic awReady,
   input axiAddrT awAddr,
   input logic wValid,
   output logic wReady,
   input dataWordT wData,
   output logic bValid,
   input logic bReady,
   output respT bResp,
   input logic arValid,
   output logic arReady,
   input axiAddrT arAddr,
   output logic rValid,
   input logic rReady,
   output dataWordT rData,
   output respT rResp
);

   localparam int IDX_W = $clog2(DEPTH);

   codeWordT injMask;
   logic injUsed;
   logic rspValid;
   dataWordT rspData;
   logic rspCorrected;
   logic rspUncorrectable;

   // front -> encode -> store -> decode
   eccPipeIf #(.IDX_W(IDX_W)) reqIf ();
   eccPipeIf #(.IDX_W(IDX_W)) storeIf ();
   eccPipeIf #(.IDX_W(IDX_W)) rdIf ();

   eccAxiFront #(.DEPTH(DEPTH)) uFront (
      .clk(clk), .rstN(rstN),
      .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
      .wValid(wValid), .wReady(wReady), .wData(wData),
      .bValid(bValid), .bReady(bReady), .bResp(bResp),
      .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
      .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
      .req(reqIf), .injMask(injMask), .injUsed(injUsed),
      .rspValid(rspValid), .rspData(rspData),
      .rspCorrected(rspCorrected), .rspUncorrectable(rspUncorrectable)
   );

   eccEncodeStage uEncode (
      .clk(clk), .rstN(rstN),
      .injMask(injMask), .injUsed(injUsed),
      .req(reqIf), .store(storeIf)
   );

   eccStore #(.DEPTH(DEPTH)) uStore (
      .clk(clk), .rstN(rstN),
      .wr(storeIf), .rd(rdIf)
   );

   eccDecodeStage uDecode (
      .clk(clk), .rstN(rstN), .rd(rdIf),
      .rspValid(rspValid), .rspData(rspData),
      .rspCorrected(rspCorrected), .rspUncorrectable(rspUncorrectable)
   );

endmodule

//--- hw/eccPipeIf.sv
`timescale 1ns/10ps

interface eccPipeIf import eccPkg::*; #(
   parameter int IDX_W = 6
) ();

   // item present this cycle
   logic valid;
   // write item, otherwise read
   logic wr;
   // word index into the store
   logic [IDX_W-1:0] idx;
   // encoded word, used between encode, store and decode
   codeWordT code;
   // raw data word, used between front and encode
   dataWordT data;

   // no ready, every stage takes an item each cycle
   modport source (
      output valid, wr, idx, code, data
   );

   modport sink (
      input valid, wr, idx, code, data
   );

endinterface

//--- hw/eccPkg.sv
package eccPkg;

   // one data nibble before encoding
   typedef logic [3:0] nibbleT;

   // hamming codeword of one nibble
   // parity at bits 0, 1, 2, 4 and data at bits 3, 5, 6, 7
   typedef logic [7:0] codeByteT;

   // axi data word
   typedef logic [31:0] dataWordT;

   // stored word, nibble n encoded into byte n
   typedef logic [63:0] codeWordT;

   // byte address on the axi side
   typedef logic [11:0] axiAddrT;

   typedef logic [1:0] respT;

   // saturating error counters, read back zero-extended
   typedef logic [15:0] cntT;

   localparam respT RESP_OKAY = 2'b00;
   localparam respT RESP_SLVERR = 2'b10;

   // data words live below this address
   localparam axiAddrT REG_BASE = 12'h800;

   // register map
   localparam axiAddrT REG_INJ_LO = 12'h800;
   localparam axiAddrT REG_INJ_HI = 12'h804;
   localparam axiAddrT REG_CORR_CNT = 12'h808;
   localparam axiAddrT REG_UNCORR_CNT = 12'h80C;

endpackage

//--- hw/eccStore.sv
`timescale 1ns/10ps

module eccStore import eccPkg::*; #(
   parameter int DEPTH = 64
) (
   input logic clk,
   input logic rstN,
   eccPipeIf.sink wr,
   eccPipeIf.source rd
);

   codeWordT mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr.valid && wr.wr) begin
         mem[wr.idx] <= wr.code;
      end
   end

   // read item comes out one cycle later
   always_ff @(posedge clk) begin
      if (!rstN) begin
         rd.valid <= 1'b0;
      end else begin
         rd.valid <= wr.valid && !wr.wr;
      end
   end

   always_ff @(posedge clk) begin
      rd.idx <= wr.idx;
      rd.code <= mem[wr.idx];
   end

   // read side only ever carries reads
   assign rd.wr = 1'b0;
   assign rd.data = '0;

   // front filters out-of-range indices before launch
   assert property (@(posedge clk) disable iff (!rstN) wr.valid |-> int'(wr.idx) < DEPTH)
      else $error("store index out of range");

endmodule

//--- hw/hammingNibbleDecoder.sv
`timescale 1ns/10ps

module hammingNibbleDecoder import eccPkg::*; (
   input codeByteT codeIn,
   output nibbleT dataOut,
   output logic errAny,
   output logic errMulti
);

   logic [3:0] syndrome;
   logic [3:0] flipBit;

   // each group is one parity bit plus the three data bits it covers
   assign syndrome[0] = codeIn[0] ^ codeIn[3] ^ codeIn[5] ^ codeIn[6];
   assign syndrome[1] = codeIn[1] ^ codeIn[3] ^ codeIn[5] ^ codeIn[7];
   assign syndrome[2] = codeIn[2] ^ codeIn[3] ^ codeIn[6] ^ codeIn[7];
   assign syndrome[3] = codeIn[4] ^ codeIn[5] ^ codeIn[6] ^ codeIn[7];

   assign errAny = |syndrome;
   // non-zero even weight means two flipped bits
   assign errMulti = errAny && !(^syndrome);

   // weight 3 syndromes point at a data bit
   // weight 1 points at a parity bit and leaves the data alone
   assign flipBit[0] = (syndrome == 4'b0111);
   assign flipBit[1] = (syndrome == 4'b1011);
   assign flipBit[2] = (syndrome == 4'b1101);
   assign flipBit[3] = (syndrome == 4'b1110);

   assign dataOut = {codeIn[7], codeIn[6], codeIn[5], codeIn[3]} ^ flipBit;

endmodule

//--- src.f
hw/eccPkg.sv
hw/eccPipeIf.sv
hw/hammingNibbleDecoder.sv
hw/eccEncodeStage.sv
hw/eccStore.sv
hw/eccDecodeStage.sv
hw/eccAxiFront.sv
hw/eccMemTop.sv
testbench/eccMemTb.sv

//--- testbench/eccMemTb.sv
`timescale 1ns/10ps

module eccMemTb import eccPkg::*; ();

   logic clk;
   logic rstN;
   logic awValid;
   logic awReady;
   axiAddrT awAddr;
   logic wValid;
   logic wReady;
   dataWordT wData;
   logic bValid;
   logic bReady;
   respT bResp;
   logic arValid;
   logic arReady;
   axiAddrT arAddr;
   logic rValid;
   logic rReady;
   dataWordT rData;
   respT rResp;

   // one entry per transaction line of the data file
   logic [7:0] opQ [$];
   axiAddrT addrQ [$];
   dataWordT wDataQ [$];
   dataWordT expQ [$];
   respT respQ [$];

   int cycleCnt = 0;
   int cycleLimit = 100;

   eccMemTop #(.DEPTH(64)) UUT (
      .clk(clk), .rstN(rstN),
      .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
      .wValid(wValid), .wReady(wReady), .wData(wData),
      .bValid(bValid), .bReady(bReady), .bResp(bResp),
      .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
      .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp)
   );

   // 4 ns period
   always #2 clk = ~clk;

   // stop a stuck handshake
   always @(posedge clk) begin
      cycleCnt <= cycleCnt + 1;
      if (cycleCnt > cycleLimit) begin
         $display("timeout after %0d cycles, DUT stopped answering", cycleCnt);
         $display("TEST FAILED");
         $fatal(1, "simulation timeout");
      end
   end

   task automatic checkValue(input string sigName, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                  $time, sigName, exp, got);
         $display("TEST FAILED");
         $fatal(1, "value mismatch on %s", sigName);
      end
   endtask

   // AW and W together, then wait for B
   task automatic axiWrite(input axiAddrT addr, input dataWordT data, output respT resp);
      awValid <= 1'b1;
      awAddr <= addr;
      wValid <= 1'b1;
      wData <= data;
      @(posedge clk);
      while (!(awReady && wReady)) @(posedge clk);
      awValid <= 1'b0;
      wValid <= 1'b0;
      bReady <= 1'b1;
      @(posedge clk);
      while (!bValid) @(posedge clk);
      // sampled at the B handshake edge
      resp = bResp;
      bReady <= 1'b0;
   endtask

   task automatic axiRead(input axiAddrT addr, output dataWordT data, output respT resp);
      arValid <= 1'b1;
      arAddr <= addr;
      @(posedge clk);
      while (!arReady) @(posedge clk);
      arValid <= 1'b0;
      rReady <= 1'b1;
      @(posedge clk);
      while (!rValid) @(posedge clk);
      data = rData;
      resp = rResp;
      rReady <= 1'b0;
   endtask

   task automatic loadTestData();
      int fd;
      int n;
      string line;
      logic [7:0] opChar;
      logic [31:0] addrTmp, wdTmp, edTmp, erTmp;
      fd = $fopen("testbench/eccMemTestdata.txt", "r");
      if (fd == 0) begin
         $display("could not open the test data file");
         $display("TEST FAILED");
         $fatal(1, "missing test data");
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) == 0) break;
         // skip comments and blank lines
         if (line.len() < 2 || line[0] == "#") continue;
         n = $sscanf(line, "%c %h %h %h %h", opChar, addrTmp, wdTmp, edTmp, erTmp);
         if (n == 5) begin
            opQ.push_back(opChar);
            addrQ.push_back(addrTmp[11:0]);
            wDataQ.push_back(wdTmp);
            expQ.push_back(edTmp);
            respQ.push_back(erTmp[1:0]);
         end
      end
      $fclose(fd);
   endtask

   initial begin
      dataWordT gotData;
      respT gotResp;
      int i;
      clk = 1'b0;
      rstN = 1'b0;
      awValid = 1'b0;
      awAddr = '0;
      wValid = 1'b0;
      wData = '0;
      bReady = 1'b0;
      arValid = 1'b0;
      arAddr = '0;
      rReady = 1'b0;

      loadTestData();
      // 20 cycles per transaction is well above the 4-cycle read path
      cycleLimit = opQ.size() * 20 + 100;

      repeat (5) @(posedge clk);
      rstN <= 1'b1;

      for (i = 0; i < opQ.size(); i++) begin
         if (opQ[i] == "W") begin
            axiWrite(addrQ[i], wDataQ[i], gotResp);
            checkValue("bResp", 32'(gotResp), 32'(respQ[i]));
         end else if (opQ[i] == "R") begin
            axiRead(addrQ[i], gotData, gotResp);
            checkValue("rResp", 32'(gotResp), 32'(respQ[i]));
            // data of an error response carries no meaning
            if (respQ[i] == RESP_OKAY) begin
               checkValue("rData", gotData, expQ[i]);
            end
         end else begin
            $display("test data line %0d has an unknown operation", i);
            $display("TEST FAILED");
            $fatal(1, "bad test data");
         end
      end

      $display("TEST OK");
      $finish;
   end

endmodule

//--- testbench/eccMemTestdata.txt
# op addr wdata expdata expresp, all hex; resp 0 = OKAY, 2 = SLVERR
# W: expdata unused; R: expdata checked only when expresp is 0
W 000 12345678 00000000 0
W 004 DEADBEEF 00000000 0
W 0FC A5A5A5A5 00000000 0
W 080 FFFFFFFF 00000000 0
R 000 00000000 12345678 0
R 004 00000000 DEADBEEF 0
R 0FC 00000000 A5A5A5A5 0
R 080 00000000 FFFFFFFF 0
W 800 00000008 00000000 0
R 800 00000000 00000008 0
W 010 CAFEF00D 00000000 0
R 800 00000000 00000000 0
R 010 00000000 CAFEF00D 0
R 808 00000000 00000001 0
W 014 01234567 00000000 0
R 014 00000000 01234567 0
R 808 00000000 00000001 0
W 800 80200108 00000000 0
W 804 10400201 00000000 0
W 020 89ABCDEF 00000000 0
R 020 00000000 89ABCDEF 0
R 808 00000000 00000002 0
W 800 00000028 00000000 0
W 024 55AA55AA 00000000 0
R 024 00000000 00000000 2
R 80C 00000000 00000001 0
R 808 00000000 00000002 0
W 100 11111111 00000000 2
R 100 00000000 00000000 2
W 7FC 22222222 00000000 2
R 7FC 00000000 00000000 2
W 810 33333333 00000000 2
R FFC 00000000 00000000 2
W 808 00000000 00000000 0
R 808 00000000 00000000 0
W 80C 00000000 00000000 0
R 80C 00000000 00000000 0
